// File: rtl/cbus_pkg.sv
package cbus_pkg;

    // byte address and data word widths, same on the cache bus and on AXI
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // low address bits that select a byte inside one data word
    localparam int BYTE_OFFSET_BITS = $clog2(DATA_WIDTH / 8);

    // a cache-bus transfer moves 2**order words, so 1 to 128 words
    localparam int CBUS_ORDER_BITS = 3;

    // beat count minus one on the cache side
    localparam int CBUS_LEN_BITS = 7;

    // AXI len field, longest burst is 16 beats
    localparam int AXI_LEN_BITS = 4;

    // upper part of the cache-side count, number of extra bursts
    localparam int ROUND_BITS = CBUS_LEN_BITS - AXI_LEN_BITS;

    // burst type used by the bridge and the RAM alike
    // set selects wrap bursts, clear selects incr bursts
    localparam logic AXI_BURST_WRAP = 1'b1;

    // on-chip RAM depth in words
    // address bits above this depth are ignored by the RAM
    localparam int RAM_WORDS = 1024;
    localparam int RAM_ADDR_BITS = $clog2(RAM_WORDS);

endpackage

// File: rtl/cbus_arbiter.sv
`timescale 1ns/1ns

module cbus_arbiter (
    input  logic clk,
    input  logic resetn,
    // instruction-cache port, reads only
    input  logic i_valid,
    input  logic [cbus_pkg::ADDR_WIDTH-1:0] i_addr,
    input  logic [cbus_pkg::CBUS_ORDER_BITS-1:0] i_order,
    output logic i_okay,
    output logic i_last,
    output logic [cbus_pkg::DATA_WIDTH-1:0] i_rdata,
    // data-cache port
    input  logic d_valid,
    input  logic d_is_write,
    input  logic [cbus_pkg::ADDR_WIDTH-1:0] d_addr,
    input  logic [cbus_pkg::CBUS_ORDER_BITS-1:0] d_order,
    input  logic [cbus_pkg::DATA_WIDTH-1:0] d_wdata,
    output logic d_okay,
    output logic d_last,
    output logic [cbus_pkg::DATA_WIDTH-1:0] d_rdata,
    // granted request toward the bridge
    output logic req_valid,
    output logic req_is_write,
    output logic [cbus_pkg::ADDR_WIDTH-1:0] req_addr,
    output logic [cbus_pkg::CBUS_ORDER_BITS-1:0] req_order,
    output logic [cbus_pkg::DATA_WIDTH-1:0] req_wdata,
    input  logic resp_okay,
    input  logic resp_last,
    input  logic [cbus_pkg::DATA_WIDTH-1:0] resp_rdata
);
    import cbus_pkg::*;

    // owner, prio and sel use 0 for the i port and 1 for the d port
    logic busy;
    logic owner;
    logic prio;
    logic sel;

    // a held grant wins, otherwise prio breaks a tie
    always_comb begin
        if (busy) begin
            sel = owner;
        end else if (i_valid && d_valid) begin
            sel = prio;
        end else begin
            sel = d_valid;
        end
    end

    assign req_valid    = sel ? d_valid : i_valid;
    assign req_is_write = sel ? d_is_write : 1'b0;
    assign req_addr     = sel ? d_addr : i_addr;
    assign req_order    = sel ? d_order : i_order;
    assign req_wdata    = sel ? d_wdata : '0;

    // responses only reach the port that holds the bus
    assign i_okay  = resp_okay && !sel;
    assign i_last  = resp_last && !sel;
    assign i_rdata = sel ? '0 : resp_rdata;
    assign d_okay  = resp_okay && sel;
    assign d_last  = resp_last && sel;
    assign d_rdata = sel ? resp_rdata : '0;

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy  <= 1'b0;
            owner <= 1'b0;
            prio  <= 1'b0;
        end else if (resp_last) begin
            // hand priority to the other port for the next tie
            busy <= 1'b0;
            prio <= ~sel;
        end else if (req_valid && !busy) begin
            busy  <= 1'b1;
            owner <= sel;
        end
    end

    // the bus stays with one master that holds its request until its last beat
    assert property (@(posedge clk) disable iff (resetn)
        busy && !resp_last |=> busy && req_valid && owner == $past(owner))
        else $error("arbiter owner changed or dropped its request during a transfer");

endmodule

// File: rtl/cbus_to_axi.sv
`timescale 1ns/1ns

module cbus_to_axi (
    input  logic clk,
    input  logic resetn,
    // granted cache-bus request
    input  logic req_valid,
    input  logic req_is_write,
    input  logic [cbus_pkg::ADDR_WIDTH-1:0] req_addr,
    input  logic [cbus_pkg::CBUS_ORDER_BITS-1:0] req_order,
    input  logic [cbus_pkg::DATA_WIDTH-1:0] req_wdata,
    output logic resp_okay,
    output logic resp_last,
    output logic [cbus_pkg::DATA_WIDTH-1:0] resp_rdata,
    // AXI4 master, write address
    output logic awvalid,
    input  logic awready,
    output logic [cbus_pkg::ADDR_WIDTH-1:0] awaddr,
    output logic [cbus_pkg::AXI_LEN_BITS-1:0] awlen,
    // write data and response
    output logic wvalid,
    input  logic wready,
    output logic [cbus_pkg::DATA_WIDTH-1:0] wdata,
    output logic wlast,
    input  logic bvalid,
    output logic bready,
    // read address and data
    output logic arvalid,
    input  logic arready,
    output logic [cbus_pkg::ADDR_WIDTH-1:0] araddr,
    output logic [cbus_pkg::AXI_LEN_BITS-1:0] arlen,
    input  logic rvalid,
    output logic rready,
    input  logic [cbus_pkg::DATA_WIDTH-1:0] rdata,
    input  logic rlast
);
    import cbus_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_transfer,
        st_request,
        st_waiting
    } state_t;

    state_t state;

    logic [AXI_LEN_BITS-1:0] axi_len;
    logic [ROUND_BITS-1:0] num_round;
    logic [ADDR_WIDTH-1:0] addr_step;
    logic [ADDR_WIDTH-1:0] burst_addr;
    logic [ADDR_WIDTH-1:0] current_addr;
    logic [ROUND_BITS-1:0] round_cnt;
    logic [AXI_LEN_BITS-1:0] len_cnt;
    logic addr_phase;
    logic addr_fire;
    logic w_fire;
    logic r_fire;
    logic b_fire;
    logic data_fire;
    logic is_last;
    logic burst_end;
    logic is_final;

    // beats minus one split into the burst len (low field) and the
    // number of bursts after the first (high field)
    // order 7 wraps to all ones
    assign {num_round, axi_len} =
        (CBUS_LEN_BITS'(1) << req_order) - CBUS_LEN_BITS'(1);

    // byte distance from one burst start to the next
    assign addr_step = (ADDR_WIDTH'(axi_len) + ADDR_WIDTH'(1)) << BYTE_OFFSET_BITS;

    // first burst comes straight from the request, later ones from the register
    assign burst_addr = (state == st_idle) ? req_addr : current_addr;
    assign addr_phase = (state == st_idle && req_valid) || state == st_request;

    assign awvalid = addr_phase && req_is_write;
    assign awaddr  = burst_addr;
    assign awlen   = axi_len;
    assign arvalid = addr_phase && !req_is_write;
    assign araddr  = burst_addr;
    assign arlen   = axi_len;

    assign wvalid = state == st_transfer && req_is_write;
    assign wdata  = req_wdata;
    assign wlast  = is_last;
    assign rready = state == st_transfer && !req_is_write;
    assign bready = state == st_waiting;

    assign addr_fire = (awvalid && awready) || (arvalid && arready);
    assign w_fire    = wvalid && wready;
    assign r_fire    = rvalid && rready;
    assign b_fire    = bvalid && bready;
    assign data_fire = w_fire || r_fire;

    // reads end a burst on rlast, writes on the local beat count
    assign is_last   = len_cnt == '0;
    assign burst_end = req_is_write ? is_last : rlast;
    assign is_final  = burst_end && round_cnt == '0;

    // the final write beat of a burst is confirmed by B, not by W
    assign resp_okay  = (req_is_write && is_last) ? b_fire : data_fire;
    assign resp_last  = is_final && (req_is_write ? b_fire : r_fire);
    assign resp_rdata = rdata;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state     <= st_idle;
            round_cnt <= '0;
            len_cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (addr_fire) begin
                        state     <= st_transfer;
                        round_cnt <= num_round;
                        len_cnt   <= axi_len;
                    end
                end
                st_transfer: begin
                    if (data_fire) begin
                        if (req_is_write && burst_end) begin
                            state <= st_waiting;
                        end else if (is_final) begin
                            state <= st_idle;
                        end else if (burst_end) begin
                            state <= st_request;
                        end else begin
                            len_cnt <= len_cnt - 1'b1;
                        end
                    end
                end
                st_request: begin
                    if (addr_fire) begin
                        state     <= st_transfer;
                        round_cnt <= round_cnt - 1'b1;
                        len_cnt   <= axi_len;
                    end
                end
                st_waiting: begin
                    if (b_fire) begin
                        state <= (round_cnt == '0) ? st_idle : st_request;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // next burst start is ready before the request state needs it
    always_ff @(posedge clk) begin
        if (addr_fire) begin
            current_addr <= burst_addr + addr_step;
        end
    end

    assert property (@(posedge clk) disable iff (resetn) !(awvalid && arvalid))
        else $error("AW and AR valid in the same cycle");

    // data phase follows the address handshake while the RAM serves that burst
    assert property (@(posedge clk) disable iff (resetn)
        addr_fire |=> !awvalid && !arvalid && !awready && !arready)
        else $error("address valid or RAM still idle during the data phase");

endmodule

// File: rtl/axi_ram.sv
`timescale 1ns/1ns

module axi_ram (
    input  logic clk,
    input  logic resetn,
    // write address
    input  logic awvalid,
    output logic awready,
    input  logic [cbus_pkg::ADDR_WIDTH-1:0] awaddr,
    input  logic [cbus_pkg::AXI_LEN_BITS-1:0] awlen,
    // write data and response
    input  logic wvalid,
    output logic wready,
    input  logic [cbus_pkg::DATA_WIDTH-1:0] wdata,
    input  logic wlast,
    output logic bvalid,
    input  logic bready,
    // read address and data
    input  logic arvalid,
    output logic arready,
    input  logic [cbus_pkg::ADDR_WIDTH-1:0] araddr,
    input  logic [cbus_pkg::AXI_LEN_BITS-1:0] arlen,
    output logic rvalid,
    input  logic rready,
    output logic [cbus_pkg::DATA_WIDTH-1:0] rdata,
    output logic rlast
);
    import cbus_pkg::*;

    typedef enum logic [1:0] {
        ram_idle,
        ram_read,
        ram_write,
        ram_resp
    } state_t;

    state_t state;

    logic [DATA_WIDTH-1:0] mem [RAM_WORDS];
    logic [RAM_ADDR_BITS-1:0] base;
    logic [AXI_LEN_BITS-1:0] len;
    logic [AXI_LEN_BITS-1:0] beat;
    logic [RAM_ADDR_BITS-1:0] start_word;
    logic [RAM_ADDR_BITS-1:0] cur_word;
    logic [RAM_ADDR_BITS-1:0] rd_word;
    logic aw_fire;
    logic ar_fire;
    logic w_fire;
    logic r_fire;
    logic rd_en;

    // word index of beat idx; wrap keeps the beat inside the block of
    // len+1 words that holds base, incr just counts up
    function automatic logic [RAM_ADDR_BITS-1:0] beat_word(
        input logic [RAM_ADDR_BITS-1:0] start,
        input logic [AXI_LEN_BITS-1:0] blen,
        input logic [AXI_LEN_BITS-1:0] idx
    );
        logic [RAM_ADDR_BITS-1:0] mask;
        logic [RAM_ADDR_BITS-1:0] sum;
        mask = RAM_ADDR_BITS'(blen);
        sum  = start + RAM_ADDR_BITS'(idx);
        if (AXI_BURST_WRAP) begin
            return (start & ~mask) | (sum & mask);
        end
        return sum;
    endfunction

    // write wins if both arrive, the bridge never does that
    assign awready = state == ram_idle;
    assign arready = state == ram_idle && !awvalid;
    assign wready  = state == ram_write;
    assign bvalid  = state == ram_resp;
    assign rvalid  = state == ram_read;
    assign rlast   = rvalid && beat == len;

    assign aw_fire = awvalid && awready;
    assign ar_fire = arvalid && arready;
    assign w_fire  = wvalid && wready;
    assign r_fire  = rvalid && rready;

    assign start_word = ar_fire ? araddr[RAM_ADDR_BITS+BYTE_OFFSET_BITS-1:BYTE_OFFSET_BITS]
                                : awaddr[RAM_ADDR_BITS+BYTE_OFFSET_BITS-1:BYTE_OFFSET_BITS];
    assign cur_word = beat_word(base, len, beat);

    // rdata is registered, so the next word is fetched on each accepted beat
    assign rd_en   = ar_fire || (r_fire && !rlast);
    assign rd_word = ar_fire ? start_word : beat_word(base, len, beat + 1'b1);

    always_ff @(posedge clk) begin
        if (aw_fire || ar_fire) begin
            base <= start_word;
            len  <= ar_fire ? arlen : awlen;
        end
        if (w_fire) begin
            mem[cur_word] <= wdata;
        end
        if (rd_en) begin
            rdata <= mem[rd_word];
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= ram_idle;
            beat  <= '0;
        end else begin
            case (state)
                ram_idle: begin
                    beat <= '0;
                    if (aw_fire) begin
                        state <= ram_write;
                    end else if (ar_fire) begin
                        state <= ram_read;
                    end
                end
                ram_read: begin
                    if (r_fire) begin
                        if (rlast) begin
                            state <= ram_idle;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                ram_write: begin
                    if (w_fire) begin
                        if (wlast) begin
                            state <= ram_resp;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                ram_resp: begin
                    if (bready) begin
                        state <= ram_idle;
                    end
                end
                default: state <= ram_idle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (resetn)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("read beat changed under back-pressure");

    assert property (@(posedge clk) disable iff (resetn)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

endmodule

// File: rtl/mem_subsystem_top.sv
`timescale 1ns/1ns

module mem_subsystem_top (
    input  logic clk,
    input  logic resetn,
    // instruction-cache port
    input  logic i_valid,
    input  logic [cbus_pkg::ADDR_WIDTH-1:0] i_addr,
    input  logic [cbus_pkg::CBUS_ORDER_BITS-1:0] i_order,
    output logic i_okay,
    output logic i_last,
    output logic [cbus_pkg::DATA_WIDTH-1:0] i_rdata,
    // data-cache port
    input  logic d_valid,
    input  logic d_is_write,
    input  logic [cbus_pkg::ADDR_WIDTH-1:0] d_addr,
    input  logic [cbus_pkg::CBUS_ORDER_BITS-1:0] d_order,
    input  logic [cbus_pkg::DATA_WIDTH-1:0] d_wdata,
    output logic d_okay,
    output logic d_last,
    output logic [cbus_pkg::DATA_WIDTH-1:0] d_rdata
);
    import cbus_pkg::*;

    // granted cache-bus request
    logic req_valid;
    logic req_is_write;
    logic [ADDR_WIDTH-1:0] req_addr;
    logic [CBUS_ORDER_BITS-1:0] req_order;
    logic [DATA_WIDTH-1:0] req_wdata;
    logic resp_okay;
    logic resp_last;
    logic [DATA_WIDTH-1:0] resp_rdata;

    // AXI4 between bridge and RAM
    logic awvalid;
    logic awready;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic [AXI_LEN_BITS-1:0] awlen;
    logic wvalid;
    logic wready;
    logic [DATA_WIDTH-1:0] wdata;
    logic wlast;
    logic bvalid;
    logic bready;
    logic arvalid;
    logic arready;
    logic [ADDR_WIDTH-1:0] araddr;
    logic [AXI_LEN_BITS-1:0] arlen;
    logic rvalid;
    logic rready;
    logic [DATA_WIDTH-1:0] rdata;
    logic rlast;

    cbus_arbiter u_arbiter (
        .clk        (clk),
        .resetn     (resetn),
        .i_valid    (i_valid),
        .i_addr     (i_addr),
        .i_order    (i_order),
        .i_okay     (i_okay),
        .i_last     (i_last),
        .i_rdata    (i_rdata),
        .d_valid    (d_valid),
        .d_is_write (d_is_write),
        .d_addr     (d_addr),
        .d_order    (d_order),
        .d_wdata    (d_wdata),
        .d_okay     (d_okay),
        .d_last     (d_last),
        .d_rdata    (d_rdata),
        .req_valid  (req_valid),
        .req_is_write (req_is_write),
        .req_addr   (req_addr),
        .req_order  (req_order),
        .req_wdata  (req_wdata),
        .resp_okay  (resp_okay),
        .resp_last  (resp_last),
        .resp_rdata (resp_rdata)
    );

    cbus_to_axi u_bridge (
        .clk        (clk),
        .resetn     (resetn),
        .req_valid  (req_valid),
        .req_is_write (req_is_write),
        .req_addr   (req_addr),
        .req_order  (req_order),
        .req_wdata  (req_wdata),
        .resp_okay  (resp_okay),
        .resp_last  (resp_last),
        .resp_rdata (resp_rdata),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wlast      (wlast),
        .bvalid     (bvalid),
        .bready     (bready),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .arlen      (arlen),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rlast      (rlast)
    );

    axi_ram u_ram (
        .clk     (clk),
        .resetn  (resetn),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wlast   (wlast),
        .bvalid  (bvalid),
        .bready  (bready),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arlen   (arlen),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rlast   (rlast)
    );

endmodule

// File: tb/tb_mem_subsystem.sv
`timescale 1ns/1ns

module tb_mem_subsystem;
    import cbus_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic clk;
    logic resetn;
    logic i_valid;
    logic [ADDR_WIDTH-1:0] i_addr;
    logic [CBUS_ORDER_BITS-1:0] i_order;
    logic i_okay;
    logic i_last;
    logic [DATA_WIDTH-1:0] i_rdata;
    logic d_valid;
    logic d_is_write;
    logic [ADDR_WIDTH-1:0] d_addr;
    logic [CBUS_ORDER_BITS-1:0] d_order;
    logic [DATA_WIDTH-1:0] d_wdata;
    logic d_okay;
    logic d_last;
    logic [DATA_WIDTH-1:0] d_rdata;

    // shadow copy of the RAM that follows each d-port write okay
    logic [DATA_WIDTH-1:0] shadow [RAM_WORDS];
    logic [DATA_WIDTH-1:0] i_expect;
    logic [DATA_WIDTH-1:0] d_expect;
    logic i_last_exp;
    logic d_last_exp;
    int i_beat;
    int d_beat;
    int errors;
    int timeouts;
    logic [31:0] lcg;

    mem_subsystem_top dut (
        .clk        (clk),
        .resetn     (resetn),
        .i_valid    (i_valid),
        .i_addr     (i_addr),
        .i_order    (i_order),
        .i_okay     (i_okay),
        .i_last     (i_last),
        .i_rdata    (i_rdata),
        .d_valid    (d_valid),
        .d_is_write (d_is_write),
        .d_addr     (d_addr),
        .d_order    (d_order),
        .d_wdata    (d_wdata),
        .d_okay     (d_okay),
        .d_last     (d_last),
        .d_rdata    (d_rdata)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // RAM word of one beat by bursts of min(N,16) beats that wrap in their aligned block
    function automatic int unsigned word_at(input logic [ADDR_WIDTH-1:0] addr,
                                            input logic [CBUS_ORDER_BITS-1:0] order,
                                            input int beat);
        int unsigned n;
        int unsigned blen;
        int unsigned start;
        int unsigned offs;
        n = 1 << order;
        blen = (n < 16) ? n : 16;
        start = (addr >> 2) + (beat / blen) * blen;
        offs = beat % blen;
        if (AXI_BURST_WRAP) begin
            return ((start - start % blen) + (start % blen + offs) % blen) % RAM_WORDS;
        end
        return (start + offs) % RAM_WORDS;
    endfunction

    assign i_expect = shadow[word_at(i_addr, i_order, i_beat)];
    assign d_expect = shadow[word_at(d_addr, d_order, d_beat)];
    assign i_last_exp = i_beat == (1 << i_order) - 1;
    assign d_last_exp = d_beat == (1 << d_order) - 1;

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    assert property (@(posedge clk) resetn |-> !i_okay && !i_last && !d_okay && !d_last)
        else begin
            errors++;
            $display("cache port response active during reset");
        end

    assert property (@(posedge clk) resetn |=> !i_okay && !i_last && !d_okay && !d_last)
        else begin
            errors++;
            $display("cache port response active right after reset");
        end

    assert property (@(posedge clk) disable iff (resetn) i_okay |-> i_rdata == i_expect)
        else begin
            errors++;
            $display("MISMATCH i_rdata got %h expected %h", $sampled(i_rdata),
                     $sampled(i_expect));
        end

    assert property (@(posedge clk) disable iff (resetn)
        d_okay && !d_is_write |-> d_rdata == d_expect)
        else begin
            errors++;
            $display("MISMATCH d_rdata got %h expected %h", $sampled(d_rdata),
                     $sampled(d_expect));
        end

    assert property (@(posedge clk) disable iff (resetn) i_okay |-> i_last == i_last_exp)
        else begin
            errors++;
            $display("MISMATCH i_last got %h expected %h", $sampled(i_last),
                     $sampled(i_last_exp));
        end

    assert property (@(posedge clk) disable iff (resetn) d_okay |-> d_last == d_last_exp)
        else begin
            errors++;
            $display("MISMATCH d_last got %h expected %h", $sampled(d_last),
                     $sampled(d_last_exp));
        end

    assert property (@(posedge clk) disable iff (resetn)
        !(i_last && !i_okay) && !(d_last && !d_okay))
        else begin
            errors++;
            $display("last seen without okay");
        end

    // okay must only go to the one port that is being served
    assert property (@(posedge clk) disable iff (resetn) !(i_okay && d_okay))
        else begin
            errors++;
            $display("okay reached both ports in one cycle");
        end

    assert property (@(posedge clk) disable iff (resetn)
        !(i_okay && !i_valid) && !(d_okay && !d_valid))
        else begin
            errors++;
            $display("okay reached a port with no request");
        end

    task automatic fetch_block(input logic [ADDR_WIDTH-1:0] addr,
                               input logic [CBUS_ORDER_BITS-1:0] order);
        int cycles;
        logic done;
        logic beat_ok;
        i_addr = addr;
        i_order = order;
        i_beat = 0;
        i_valid = 1'b1;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            beat_ok = i_okay;
            done = i_okay && i_last;
            @(posedge clk);
            #1;
            cycles++;
            if (beat_ok) begin
                i_beat++;
            end
        end
        i_valid = 1'b0;
        if (!done) begin
            timeouts++;
            $display("i port read at %h order %0d timed out", addr, order);
        end
    endtask

    task automatic data_access(input logic write, input logic [ADDR_WIDTH-1:0] addr,
                               input logic [CBUS_ORDER_BITS-1:0] order);
        int cycles;
        logic done;
        logic beat_ok;
        d_is_write = write;
        d_addr = addr;
        d_order = order;
        d_beat = 0;
        if (write) begin
            lcg = next_rand(lcg);
            d_wdata = lcg;
        end
        d_valid = 1'b1;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            beat_ok = d_okay;
            done = d_okay && d_last;
            if (d_okay && write) begin
                shadow[word_at(addr, order, d_beat)] = d_wdata;
            end
            @(posedge clk);
            #1;
            cycles++;
            if (beat_ok) begin
                d_beat++;
                // master presents the next word after each okay
                if (write) begin
                    lcg = next_rand(lcg);
                    d_wdata = lcg;
                end
            end
        end
        d_valid = 1'b0;
        d_is_write = 1'b0;
        if (!done) begin
            timeouts++;
            $display("d port access at %h order %0d timed out", addr, order);
        end
    endtask

    initial begin
        resetn = 1'b1;
        i_valid = 1'b0;
        i_addr = '0;
        i_order = '0;
        d_valid = 1'b0;
        d_is_write = 1'b0;
        d_addr = '0;
        d_order = '0;
        d_wdata = '0;
        i_beat = 0;
        d_beat = 0;
        errors = 0;
        timeouts = 0;
        lcg = 32'd19;
        repeat (8) @(posedge clk);
        #1;
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        // single word write and read back
        data_access(1'b1, 32'h100, 3'd0);
        data_access(1'b0, 32'h100, 3'd0);
        // 8 words from word 70 that wrap inside words 64 to 71
        data_access(1'b1, 32'h118, 3'd3);
        data_access(1'b0, 32'h118, 3'd3);
        fetch_block(32'h10c, 3'd3);
        // 64 words as four 16-beat bursts
        data_access(1'b1, 32'h414, 3'd6);
        data_access(1'b0, 32'h414, 3'd6);
        fetch_block(32'h428, 3'd5);
        // both ports at once
        fork
            begin
                fetch_block(32'h118, 3'd3);
                fetch_block(32'h414, 3'd6);
                fetch_block(32'h100, 3'd0);
                fetch_block(32'h410, 3'd4);
            end
            begin
                data_access(1'b1, 32'h4b0, 3'd4);
                data_access(1'b1, 32'h108, 3'd2);
                data_access(1'b0, 32'h4b0, 3'd4);
                data_access(1'b0, 32'h118, 3'd3);
            end
        join
        repeat (4) @(posedge clk);
        $display("errors %0d timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: build.f
rtl/cbus_pkg.sv
rtl/cbus_arbiter.sv
rtl/cbus_to_axi.sv
rtl/axi_ram.sv
rtl/mem_subsystem_top.sv
tb/tb_mem_subsystem.sv

// File: Makefile
TOP = tb_mem_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
